// File: Makefile
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP ?= conv_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the testbench prints the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
hdl/conv_pkg.sv
hdl/row_window.sv
hdl/window_majority.sv
hdl/row_assembler.sv
hdl/conv_ctrl.sv
hdl/conv_top.sv
sim/conv_asserts.sv
sim/conv_tb.sv

// File: hdl/conv_ctrl.sv
// control fsm of the convolution engine; parses headers, feeds rows and columns, owns run/busy
`timescale 1ns/1ns
module conv_ctrl #(
	parameter conv_pkg::addr_t IN_BASE_ADDR = '0
) (
	input logic clk,
	input logic reset_b,
	input logic run,
	output logic busy,
	output conv_pkg::addr_t sram_read_address,
	input conv_pkg::sram_word_u sram_read_data,
	output conv_pkg::addr_t wmem_read_address,
	input conv_pkg::word_t wmem_read_data,
	output logic row_load,
	output logic row_shift,
	output logic kernel_load,
	output conv_pkg::kernel_t kernel,
	output logic col_valid,
	output conv_pkg::col_idx_t col_idx,
	output logic row_last,
	output conv_pkg::col_idx_t out_cols_max,
	input logic pipe_idle
);
	import conv_pkg::*;

	// latency of window_majority, col_valid to bit_valid
	localparam int PIPE_DEPTH = 3;

	// fsm states
	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_ADDR = 3'd1;
	localparam logic [2:0] S_HDR_ROWS = 3'd2;
	localparam logic [2:0] S_HDR_COLS = 3'd3;
	localparam logic [2:0] S_PRELOAD = 3'd4;
	localparam logic [2:0] S_SWEEP = 3'd5;
	localparam logic [2:0] S_DRAIN = 3'd6;

	logic [2:0] state;
	// next input word to fetch
	addr_t rd_addr;
	// image rows not yet in the window
	addr_t rows_left;
	// column count minus one
	col_idx_t cols_max;
	col_idx_t cidx;
	// shared step counter for preload and drain
	logic [1:0] step;
	logic end_seen;

	// header word equal to the end marker
	assign end_seen = (sram_read_data.count == END_MARKER);

	// read address always points at the word needed next cycle
	assign sram_read_address = rd_addr;
	assign wmem_read_address = (state == S_ADDR) ? KERNEL_ADDR : '0;

	// kernel arrives with the row count word
	assign kernel_load = (state == S_HDR_ROWS) && !end_seen;
	assign kernel = wmem_read_data[$bits(kernel_t)-1:0];

	// column sweep
	assign col_valid = (state == S_SWEEP);
	assign col_idx = cidx;
	assign row_last = col_valid && (cidx == cols_max);
	assign out_cols_max = cols_max - col_idx_t'(KERNEL_DIM - 1);

	// preload shifts every word in; in a sweep the next row is staged at column 1
	assign row_load = (state == S_PRELOAD) ||
		(col_valid && (cidx == col_idx_t'(1)) && (rows_left != '0));
	assign row_shift = (state == S_PRELOAD) || (row_last && (rows_left != '0));

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= S_IDLE;
			busy <= 1'b0;
			rd_addr <= IN_BASE_ADDR;
			rows_left <= '0;
			cols_max <= '0;
			cidx <= '0;
			step <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					rd_addr <= IN_BASE_ADDR;
					// busy acknowledges run one edge later
					if (run) begin
						busy <= 1'b1;
						state <= S_ADDR;
					end
				end
				S_ADDR: begin
					// row count address on the bus
					rd_addr <= rd_addr + 1'b1;
					state <= S_HDR_ROWS;
				end
				S_HDR_ROWS: begin
					// pipe already drained, so busy can drop right away
					if (end_seen) begin
						busy <= 1'b0;
						state <= S_IDLE;
					end else begin
						rows_left <= addr_t'(sram_read_data.count - KERNEL_DIM);
						rd_addr <= rd_addr + 1'b1;
						state <= S_HDR_COLS;
					end
				end
				S_HDR_COLS: begin
					cols_max <= col_idx_t'(sram_read_data.count - 1);
					rd_addr <= rd_addr + 1'b1;
					step <= '0;
					state <= S_PRELOAD;
				end
				S_PRELOAD: begin
					step <= step + 1'b1;
					// third row leaves the fourth row address on the bus
					if (step == 2'(KERNEL_DIM - 1)) begin
						cidx <= '0;
						state <= S_SWEEP;
					end else begin
						rd_addr <= rd_addr + 1'b1;
					end
				end
				S_SWEEP: begin
					if (row_load)
						rd_addr <= rd_addr + 1'b1;
					if (cidx == cols_max) begin
						cidx <= '0;
						if (rows_left != '0) begin
							rows_left <= rows_left - 1'b1;
						end else begin
							step <= '0;
							state <= S_DRAIN;
						end
					end else begin
						cidx <= cidx + 1'b1;
					end
				end
				S_DRAIN: begin
					// give the last column time to reach the assembler
					if (step != 2'(PIPE_DEPTH - 1))
						step <= step + 1'b1;
					else if (pipe_idle)
						state <= S_ADDR;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hdl/conv_pkg.sv
// shared types and constants for the 3x3 binary convolution engine, imported by every rtl file
package conv_pkg;

	// geometry of the engine
	localparam int MAX_COLS = 16;
	localparam int KERNEL_DIM = 3;

	// memory address, 12 bits
	typedef logic [11:0] addr_t;

	// memory data word
	typedef logic [15:0] word_t;

	// one input sram word, decoded two ways
	// pixels: bit c is image column c
	// count: row or column count of an image header
	typedef union packed {
		logic [MAX_COLS-1:0] pixels;
		word_t count;
	} sram_word_u;

	// kernel weights, bit 3r+c is row r column c
	typedef logic [KERNEL_DIM*KERNEL_DIM-1:0] kernel_t;

	// column index within a row
	typedef logic [$clog2(MAX_COLS)-1:0] col_idx_t;

	// row count word that ends a run
	localparam word_t END_MARKER = 16'h00FF;

	// weight memory word holding the kernel
	localparam addr_t KERNEL_ADDR = 12'd1;

endpackage

// File: hdl/conv_top.sv
// top level of the convolution engine; connects ctrl, row window, majority pipe and row assembler
`timescale 1ns/1ns
module conv_top #(
	parameter conv_pkg::addr_t IN_BASE_ADDR = '0,
	parameter conv_pkg::addr_t OUT_BASE_ADDR = '0
) (
	input logic clk,
	input logic reset_b,
	input logic run,
	output logic busy,
	output conv_pkg::addr_t sram_read_address,
	input conv_pkg::word_t sram_read_data,
	output conv_pkg::addr_t wmem_read_address,
	input conv_pkg::word_t wmem_read_data,
	output conv_pkg::addr_t write_address,
	output conv_pkg::word_t write_data,
	output logic write_enable
);
	import conv_pkg::*;

	// ctrl to row window
	logic row_load;
	logic row_shift;

	// ctrl to majority pipe
	logic kernel_load;
	kernel_t kernel;
	logic col_valid;
	col_idx_t col_idx;
	logic row_last;

	// window column slice, top row in bit 0
	logic [2:0] slice;

	// majority pipe to assembler
	logic bit_valid;
	logic bit_value;
	col_idx_t bit_col;
	logic row_end;

	// assembler bookkeeping
	col_idx_t out_cols_max;
	logic pipe_idle;

	conv_ctrl #(
		.IN_BASE_ADDR(IN_BASE_ADDR)
	) conv_ctrl_i (
		.clk(clk),
		.reset_b(reset_b),
		.run(run),
		.busy(busy),
		.sram_read_address(sram_read_address),
		.sram_read_data(sram_read_data),
		.wmem_read_address(wmem_read_address),
		.wmem_read_data(wmem_read_data),
		.row_load(row_load),
		.row_shift(row_shift),
		.kernel_load(kernel_load),
		.kernel(kernel),
		.col_valid(col_valid),
		.col_idx(col_idx),
		.row_last(row_last),
		.out_cols_max(out_cols_max),
		.pipe_idle(pipe_idle)
	);

	// row words come straight off the read port
	row_window row_window_i (
		.clk(clk),
		.reset_b(reset_b),
		.row_in(sram_read_data),
		.row_load(row_load),
		.row_shift(row_shift),
		.col_idx(col_idx),
		.slice(slice)
	);

	window_majority window_majority_i (
		.clk(clk),
		.reset_b(reset_b),
		.kernel_load(kernel_load),
		.kernel(kernel),
		.slice(slice),
		.col_valid(col_valid),
		.col_idx(col_idx),
		.row_last(row_last),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.bit_col(bit_col),
		.row_end(row_end)
	);

	row_assembler #(
		.OUT_BASE_ADDR(OUT_BASE_ADDR)
	) row_assembler_i (
		.clk(clk),
		.reset_b(reset_b),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.bit_col(bit_col),
		.row_end(row_end),
		.out_cols_max(out_cols_max),
		.pipe_idle(pipe_idle),
		.write_address(write_address),
		.write_data(write_data),
		.write_enable(write_enable)
	);

endmodule

// File: hdl/row_assembler.sv
// output row builder of the convolution engine; packs result bits and writes one word per row
`timescale 1ns/1ns
module row_assembler #(
	parameter conv_pkg::addr_t OUT_BASE_ADDR = '0
) (
	input logic clk,
	input logic reset_b,
	input logic bit_valid,
	input logic bit_value,
	input conv_pkg::col_idx_t bit_col,
	input logic row_end,
	input conv_pkg::col_idx_t out_cols_max,
	output logic pipe_idle,
	output conv_pkg::addr_t write_address,
	output conv_pkg::word_t write_data,
	output logic write_enable
);
	import conv_pkg::*;

	// row being built
	word_t acc;
	word_t acc_next;
	// next output address, runs on until reset
	addr_t wr_ptr;
	// bits collected but row not yet closed
	logic row_open;
	logic take;
	logic row_done;

	// drop bits past the last valid output column
	assign take = bit_valid && (bit_col <= out_cols_max);
	assign row_done = bit_valid && row_end;

	always_comb begin
		acc_next = acc;
		if (take)
			acc_next[bit_col] = bit_value;
	end

	// nothing arriving, nothing half built, nothing on the write port
	assign pipe_idle = !bit_valid && !row_open && !write_enable;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			acc <= '0;
			wr_ptr <= OUT_BASE_ADDR;
			row_open <= 1'b0;
			write_enable <= 1'b0;
		end else begin
			// one-cycle write pulse after the row end bit
			write_enable <= row_done;
			if (row_done) begin
				acc <= '0;
				wr_ptr <= wr_ptr + 1'b1;
				row_open <= 1'b0;
			end else begin
				acc <= acc_next;
				if (bit_valid)
					row_open <= 1'b1;
			end
		end
	end

	// write payload, includes the row end bit itself
	always_ff @(posedge clk) begin
		if (row_done) begin
			write_data <= acc_next;
			write_address <= wr_ptr;
		end
	end

endmodule

// File: hdl/row_window.sv
// three-row pixel buffer of the convolution engine; gives one column slice per cycle
`timescale 1ns/1ns
module row_window (
	input logic clk,
	input logic reset_b,
	input conv_pkg::word_t row_in,
	input logic row_load,
	input logic row_shift,
	input conv_pkg::col_idx_t col_idx,
	output logic [2:0] slice
);
	import conv_pkg::*;

	// input word viewed as a pixel row
	sram_word_u in_word;

	// window rows, top is kernel row 0
	word_t row_top;
	word_t row_mid;
	word_t row_bot;
	// next image row, fetched during the sweep
	word_t row_next;

	assign in_word = row_in;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			row_top <= '0;
			row_mid <= '0;
			row_bot <= '0;
			row_next <= '0;
		end else begin
			// load alone only stages the word
			if (row_load && !row_shift)
				row_next <= in_word.pixels;
			// load with shift puts the word straight in at the bottom
			if (row_shift) begin
				row_top <= row_mid;
				row_mid <= row_bot;
				row_bot <= row_load ? in_word.pixels : row_next;
			end
		end
	end

	// current column of each row
	assign slice = {row_bot[col_idx], row_mid[col_idx], row_top[col_idx]};

endmodule

// File: hdl/window_majority.sv
// kernel compare and majority pipe of the convolution engine; 3 cycles from column in to bit out
`timescale 1ns/1ns
module window_majority (
	input logic clk,
	input logic reset_b,
	input logic kernel_load,
	input conv_pkg::kernel_t kernel,
	input logic [2:0] slice,
	input logic col_valid,
	input conv_pkg::col_idx_t col_idx,
	input logic row_last,
	output logic bit_valid,
	output logic bit_value,
	output conv_pkg::col_idx_t bit_col,
	output logic row_end
);
	import conv_pkg::*;

	// full adder, returns {carry, sum}
	function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
		fa = {(a & b) | (c & (a ^ b)), a ^ b ^ c};
	endfunction

	// slices of the two previous columns
	logic [2:0] hist1;
	logic [2:0] hist2;
	kernel_t kern_q;
	kernel_t window;
	// stage 1, mismatch bits
	kernel_t mism;
	// stage 2, ones and twos of each kernel row
	logic [2:0] ones2;
	logic [2:0] twos2;
	// stage 3, weights 1, 2, 2 and 4
	logic ones3;
	logic twos3a;
	logic twos3b;
	logic fours3;
	// tags riding along with the data
	logic v1, v2, v3;
	col_idx_t col1, col2, col3;
	logic last1, last2, last3;

	// hist2 is the leftmost window column
	always_comb begin
		for (int r = 0; r < KERNEL_DIM; r++) begin
			window[KERNEL_DIM*r] = hist2[r];
			window[KERNEL_DIM*r + 1] = hist1[r];
			window[KERNEL_DIM*r + 2] = slice[r];
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			kern_q <= '0;
			hist1 <= '0;
			hist2 <= '0;
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			if (kernel_load)
				kern_q <= kernel;
			if (col_valid) begin
				hist2 <= hist1;
				hist1 <= slice;
			end
			// full window from the third column on
			v1 <= col_valid && (col_idx >= col_idx_t'(KERNEL_DIM - 1));
			v2 <= v1;
			v3 <= v2;
		end
	end

	always_ff @(posedge clk) begin
		mism <= window ^ kern_q;
		col1 <= col_idx - col_idx_t'(KERNEL_DIM - 1);
		last1 <= row_last;
		// first adder stage, one adder per kernel row
		for (int k = 0; k < KERNEL_DIM; k++)
			{twos2[k], ones2[k]} <= fa(mism[3*k], mism[3*k + 1], mism[3*k + 2]);
		col2 <= col1;
		last2 <= last1;
		// second stage folds the ones and the twos
		{twos3a, ones3} <= fa(ones2[0], ones2[1], ones2[2]);
		{fours3, twos3b} <= fa(twos2[0], twos2[1], twos2[2]);
		col3 <= col2;
		last3 <= last2;
	end

	// 5 or more mismatches gives 0
	assign bit_value = !((ones3 & twos3a & twos3b) | ((ones3 | twos3a | twos3b) & fours3));
	assign bit_valid = v3;
	assign bit_col = col3;
	assign row_end = last3;

endmodule

// File: sim/conv_asserts.sv
// concurrent checks on busy and the output write port that the testbench binds to conv_top
`timescale 1ns/1ns
module conv_asserts (
	input logic clk,
	input logic reset_b,
	input logic run,
	input logic busy,
	input logic write_enable,
	input conv_pkg::addr_t write_address
);
	import conv_pkg::*;

	// failed check count read at the end of the run
	int unsigned fails = 0;
	// address of the previous write since reset
	addr_t last_addr;
	logic seen_write;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			last_addr <= '0;
			seen_write <= 1'b0;
		end else if (write_enable) begin
			last_addr <= write_address;
			seen_write <= 1'b1;
		end
	end

	// no output write outside a session
	write_in_session: assert property (@(posedge clk) disable iff (!reset_b)
		write_enable |-> busy)
	else begin
		$error("write_enable high while busy is low");
		fails = fails + 1;
	end

	// out of reset busy stays low until run asks for a session
	idle_until_run: assert property (@(posedge clk) disable iff (!reset_b)
		!busy && !run |=> !busy)
	else begin
		$error("busy rose without run");
		fails = fails + 1;
	end

	// output rows land at consecutive addresses
	write_addr_step: assert property (@(posedge clk) disable iff (!reset_b)
		write_enable && seen_write |-> write_address == last_addr + addr_t'(1))
	else begin
		$error("write address did not follow the previous one");
		fails = fails + 1;
	end

	// single-cycle write pulse
	write_pulse: assert property (@(posedge clk) disable iff (!reset_b)
		write_enable |=> !write_enable)
	else begin
		$error("write_enable high for more than one cycle");
		fails = fails + 1;
	end

endmodule

// File: sim/conv_tb.sv
// testbench for the convolution engine; loads sram models, runs run/busy sessions, checks writes
`timescale 1ns/1ns
module conv_tb;
	import conv_pkg::*;

	// non-zero bases so address offsets get exercised
	localparam addr_t IN_BASE = 12'h020;
	localparam addr_t OUT_BASE = 12'h400;
	localparam int RISE_LIMIT = 20;
	localparam int FALL_LIMIT = 4000;

	logic clk = 1'b0;
	logic reset_b = 1'b0;
	logic run = 1'b0;
	logic busy;
	addr_t sram_read_address;
	word_t sram_read_data = '0;
	addr_t wmem_read_address;
	word_t wmem_read_data = '0;
	addr_t write_address;
	word_t write_data;
	logic write_enable;

	word_t in_mem [4096];
	word_t wmem [4096];
	word_t out_mem [4096];
	// write addresses in issue order
	addr_t got_addr [$];
	// rows the engine should write in order
	word_t exp_rows [$];
	// pixel rows of the image being built
	word_t img [MAX_COLS];
	addr_t put_ptr;
	kernel_t cur_kernel;
	integer seed = 32'h4765;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	always #4 clk = ~clk;

	conv_top #(
		.IN_BASE_ADDR(IN_BASE),
		.OUT_BASE_ADDR(OUT_BASE)
	) conv_top_i (
		.clk(clk),
		.reset_b(reset_b),
		.run(run),
		.busy(busy),
		.sram_read_address(sram_read_address),
		.sram_read_data(sram_read_data),
		.wmem_read_address(wmem_read_address),
		.wmem_read_data(wmem_read_data),
		.write_address(write_address),
		.write_data(write_data),
		.write_enable(write_enable)
	);

	bind conv_top conv_asserts conv_asserts_i (
		.clk(clk),
		.reset_b(reset_b),
		.run(run),
		.busy(busy),
		.write_enable(write_enable),
		.write_address(write_address)
	);

	// input sram and weight memory with one cycle read latency
	always @(posedge clk) begin
		sram_read_data <= in_mem[sram_read_address];
		wmem_read_data <= wmem[wmem_read_address];
	end

	// output memory sampled mid cycle where the write port is stable
	always @(negedge clk) begin
		if (write_enable) begin
			out_mem[write_address] = write_data;
			got_addr.push_back(write_address);
		end
	end

	// reference output row from three image rows
	function automatic word_t ref_row(input word_t top, input word_t mid, input word_t bot,
		input int cols, input kernel_t k);
		word_t res;
		word_t rows3 [3];
		int miss;
		res = '0;
		rows3[0] = top;
		rows3[1] = mid;
		rows3[2] = bot;
		// j is the leftmost window column
		for (int j = 0; j + 2 < cols; j++) begin
			miss = 0;
			for (int r = 0; r < 3; r++)
				for (int c = 0; c < 3; c++)
					if (rows3[r][j + c] != k[3 * r + c])
						miss++;
			res[j] = (miss <= 4);
		end
		return res;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected address %h actual address %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("MISMATCH %s expected %0d writes actual %0d writes", name, exp, act);
		end
	endtask

	task automatic end_run(input bit failed);
		if (failed)
			$display("Finished with errors");
		else
			$display("Finished with no errors");
		$finish;
	endtask

	task automatic timeout_abort(input string what, input string name);
		$display("timeout waiting for %s in test %s", what, name);
		end_run(1'b1);
	endtask

	// address-dependent fill and empty logs before each test
	task automatic clear_memories();
		for (int a = 0; a < 4096; a++) begin
			in_mem[a] = {4'h3, 12'(a)};
			wmem[a] = {4'h6, 12'(a)};
			out_mem[a] = {4'h9, 12'(a)};
		end
		got_addr.delete();
		exp_rows.delete();
		put_ptr = IN_BASE;
	endtask

	task automatic set_kernel(input kernel_t k);
		cur_kernel = k;
		wmem[KERNEL_ADDR] = word_t'(k);
	endtask

	// bits past the last column stay random since the engine never reads them
	task automatic random_image(input int rows);
		for (int r = 0; r < rows; r++)
			img[r] = word_t'($random(seed));
	endtask

	// header and rows of one image plus its expected output rows
	task automatic put_image(input int rows, input int cols);
		in_mem[put_ptr] = word_t'(rows);
		in_mem[put_ptr + addr_t'(1)] = word_t'(cols);
		for (int r = 0; r < rows; r++)
			in_mem[put_ptr + addr_t'(2 + r)] = img[r];
		for (int r = 0; r + 2 < rows; r++)
			exp_rows.push_back(ref_row(img[r], img[r + 1], img[r + 2], cols, cur_kernel));
		put_ptr = put_ptr + addr_t'(rows + 2);
	endtask

	task automatic put_end();
		in_mem[put_ptr] = END_MARKER;
	endtask

	// reset also rewinds the output address
	task automatic apply_reset();
		@(posedge clk);
		reset_b <= 1'b0;
		run <= 1'b0;
		repeat (8) @(posedge clk);
		reset_b <= 1'b1;
	endtask

	// four-phase run/busy handshake around one session
	task automatic run_session(input string name);
		int n;
		@(posedge clk);
		run <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!busy && n < RISE_LIMIT);
		if (!busy)
			timeout_abort("busy to rise", name);
		// drop run while busy and wait for the end of processing
		@(posedge clk);
		run <= 1'b0;
		n = 0;
		while (busy && n < FALL_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (busy)
			timeout_abort("busy to fall", name);
	endtask

	// every expected row at the next address in order
	task automatic verify_writes(input string name);
		check_count(name, exp_rows.size(), got_addr.size());
		for (int k = 0; k < exp_rows.size(); k++) begin
			if (k < got_addr.size())
				check_addr(name, OUT_BASE + addr_t'(k), got_addr[k]);
			check_word(name, exp_rows[k], out_mem[OUT_BASE + addr_t'(k)]);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_before);
	endtask

	task automatic test_single_3x3();
		int e;
		e = errors;
		clear_memories();
		set_kernel('0);
		for (int r = 0; r < 3; r++)
			img[r] = '0;
		put_image(3, 3);
		put_end();
		apply_reset();
		run_session("single_3x3");
		verify_writes("single_3x3");
		// zero window against zero kernel gives no mismatch
		check_word("single_3x3", 16'h0001, out_mem[OUT_BASE]);
		report_test("single_3x3", e);
	endtask

	task automatic test_random_full();
		int e;
		e = errors;
		clear_memories();
		set_kernel(kernel_t'($random(seed)));
		random_image(16);
		put_image(16, 16);
		put_end();
		apply_reset();
		run_session("random_full");
		verify_writes("random_full");
		// only 14 windows fit in 16 columns
		for (int k = 0; k < 14; k++)
			check_word("random_full", 16'h0000, out_mem[OUT_BASE + addr_t'(k)] & 16'hC000);
		report_test("random_full", e);
	endtask

	task automatic test_narrow();
		int e;
		e = errors;
		clear_memories();
		set_kernel(kernel_t'($random(seed)));
		random_image(5);
		put_image(5, 8);
		put_end();
		apply_reset();
		run_session("narrow");
		verify_writes("narrow");
		check_count("narrow", 3, got_addr.size());
		// output columns 0 to 5 only
		for (int k = 0; k < 3; k++)
			check_word("narrow", 16'h0000, out_mem[OUT_BASE + addr_t'(k)] & 16'hFFC0);
		report_test("narrow", e);
	endtask

	task automatic test_two_images();
		int e;
		e = errors;
		clear_memories();
		set_kernel(kernel_t'($random(seed)));
		random_image(4);
		put_image(4, 6);
		random_image(3);
		put_image(3, 10);
		put_end();
		apply_reset();
		run_session("two_images");
		// three rows with the second image right after the first
		verify_writes("two_images");
		report_test("two_images", e);
	endtask

	task automatic test_end_marker();
		int e;
		e = errors;
		clear_memories();
		put_end();
		apply_reset();
		run_session("end_marker");
		verify_writes("end_marker");
		report_test("end_marker", e);
	endtask

	initial begin
		test_single_3x3();
		test_random_full();
		test_narrow();
		test_two_images();
		test_end_marker();
		errors += int'(conv_top_i.conv_asserts_i.fails);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		end_run(errors != 0);
	end

endmodule
